//--- design/icache_cfg.svh
// =========================================================================
// geometry and field widths of the instruction cache
// include wherever a width or a count is needed
// the packages build their types from these values
// =========================================================================
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// associativity, must be a power of two
`define ICACHE_WAYS 4

// number of sets
`define ICACHE_SETS 16

// 32-bit words per line
`define ICACHE_LINE_WORDS 4

// physical address width
`define ICACHE_ADDR_WIDTH 32

// derived address fields
`define ICACHE_OFS_WIDTH ($clog2(`ICACHE_LINE_WORDS) + 2)
`define ICACHE_IDX_WIDTH ($clog2(`ICACHE_SETS))
`define ICACHE_TAG_WIDTH (`ICACHE_ADDR_WIDTH - `ICACHE_IDX_WIDTH - `ICACHE_OFS_WIDTH)

`endif

//--- design/icache_pkg.sv
// =========================================================================
// cache organization types
// shared by the cache RTL and the testbench
// all widths come from the geometry macros
// =========================================================================
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  // physical fetch address
  typedef logic [`ICACHE_ADDR_WIDTH-1:0] paddr_t;

  // address fields
  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;
  typedef logic [`ICACHE_IDX_WIDTH-1:0] idx_t;

  // way number
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

  // one full line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

  typedef logic [31:0] instr_t;

  // tree bits of one set, node 0 is the root
  typedef logic [`ICACHE_WAYS-2:0] plru_t;

endpackage

`default_nettype wire

//--- design/refill_bus_pkg.sv
// =========================================================================
// types of the read-burst bus between the cache and memory
// =========================================================================
`default_nettype none

`include "icache_cfg.svh"

package refill_bus_pkg;

  // start address of a burst, line aligned
  typedef logic [`ICACHE_ADDR_WIDTH-1:0] bus_addr_t;

  typedef logic [31:0] bus_data_t;

  // number of beats in a burst
  typedef logic [7:0] burst_len_t;

endpackage

`default_nettype wire

//--- design/sdp_ram.sv
// =========================================================================
// simple dual-port RAM, one write port and one registered read port
// payload type set per instance (tags, lines, PLRU bits)
// write-first, so a read of the address being written sees the new data
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  payload_t                 wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output payload_t                 rdata_o
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem[waddr_i] <= wdata_i;
      end
      // bypass on a same-address write
      if (we_i && (waddr_i == raddr_i)) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem[raddr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/plru_tree.sv
// =========================================================================
// tree pseudo-LRU for one set
// victim follows the node bits from the root, 0 goes left, 1 goes right
// update points every node on the path away from the accessed way
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module plru_tree #(
  parameter int WAYS = `ICACHE_WAYS
) (
  input  icache_pkg::plru_t tree_i,
  input  icache_pkg::way_t  hit_way_i,
  output icache_pkg::way_t  victim_o,
  output icache_pkg::plru_t tree_o
);

  localparam int LEVELS = $clog2(WAYS);

  // walk down from the root, msb of the way first
  always_comb begin : find_victim
    int unsigned node;
    node     = 0;
    victim_o = '0;
    for (int l = 0; l < LEVELS; l++) begin
      victim_o[LEVELS-1-l] = tree_i[node];
      node = 2 * node + 1 + tree_i[node];
    end
  end

  // children of node n sit at 2n+1 (left) and 2n+2 (right)
  always_comb begin : update_tree
    int unsigned node;
    node   = 0;
    tree_o = tree_i;
    for (int l = 0; l < LEVELS; l++) begin
      tree_o[node] = ~hit_way_i[LEVELS-1-l];
      node = 2 * node + 1 + hit_way_i[LEVELS-1-l];
    end
  end

endmodule

`default_nettype wire

//--- design/icache_refill.sv
// =========================================================================
// refill engine of the instruction cache
// takes a miss pulse, issues one line-aligned read burst and collects
// the beats into a line buffer, then pulses fill_o for one cycle
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_refill (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       miss_i,
  input  icache_pkg::paddr_t         miss_addr_i,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  refill_bus_pkg::bus_data_t  r_data_i,
  input  logic                       r_last_i,
  output logic                       ar_valid_o,
  output refill_bus_pkg::bus_addr_t  ar_addr_o,
  output refill_bus_pkg::burst_len_t ar_len_o,
  output logic                       r_ready_o,
  output logic                       fill_o,
  output icache_pkg::line_t          fill_line_o
);

  import icache_pkg::*;
  import refill_bus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } state_e;

  state_e                                state_q;
  logic [$clog2(`ICACHE_LINE_WORDS)-1:0] beat_q;
  logic                                  fill_q;
  logic                                  beat_ok;
  bus_addr_t                             addr_q;
  line_t                                 line_q;

  assign beat_ok     = r_valid_i && r_ready_o;
  assign ar_valid_o  = (state_q == MISS);
  assign ar_addr_o   = addr_q;
  assign ar_len_o    = burst_len_t'(`ICACHE_LINE_WORDS);
  assign r_ready_o   = (state_q == REFILL);
  assign fill_o      = fill_q;
  assign fill_line_o = line_q;

  // ======================================================================
  // FSM and beat counter
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      fill_q  <= 1'b0;
    end else begin
      fill_q <= beat_ok && r_last_i;
      case (state_q)
        IDLE:    if (miss_i) state_q <= MISS;
        MISS:    if (ar_ready_i) state_q <= REFILL;
        REFILL:  if (beat_ok && r_last_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
      if (state_q != REFILL) begin
        beat_q <= '0;
      end else if (beat_ok) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // burst address and line buffer
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && miss_i) begin
      addr_q <= {miss_addr_i[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFS_WIDTH],
                 {`ICACHE_OFS_WIDTH{1'b0}}};
    end
    if (beat_ok) begin
      line_q[32*beat_q +: 32] <= r_data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/icache_core.sv
// =========================================================================
// lookup pipeline of the instruction cache
// stage 0 issues the set index to the RAMs, stage 1 compares tags and
// returns one word; a miss holds stage 1 until the refill has installed
// the line, then the lookup is replayed
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    req_valid_i,
  input  icache_pkg::paddr_t      req_addr_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output icache_pkg::instr_t      rsp_instr_o,
  output icache_pkg::paddr_t      rsp_addr_o,
  output logic                    rsp_err_o,
  input  icache_pkg::tag_t        tag_rdata_i [`ICACHE_WAYS],
  input  icache_pkg::line_t       data_rdata_i [`ICACHE_WAYS],
  input  icache_pkg::plru_t       plru_rdata_i,
  input  logic                    fill_i,
  input  icache_pkg::line_t       fill_line_i,
  output logic                    miss_o,
  output icache_pkg::paddr_t      miss_addr_o,
  output icache_pkg::way_t        victim_o,
  output logic [`ICACHE_WAYS-1:0] tag_we_o,
  output icache_pkg::tag_t        tag_wdata_o,
  output logic [`ICACHE_WAYS-1:0] data_we_o,
  output icache_pkg::line_t       data_wdata_o,
  output logic                    plru_we_o,
  output icache_pkg::plru_t       plru_wdata_o,
  output icache_pkg::idx_t        ram_raddr_o,
  output icache_pkg::idx_t        ram_waddr_o
);

  import icache_pkg::*;

  logic                         init_q;
  logic                         pend_q;
  logic                         replay_q;
  logic                         s1_valid_q;
  logic                         s1_err_q;
  paddr_t                       s1_addr_q;
  logic [`ICACHE_WAYS-1:0]      valid_q [`ICACHE_SETS];
  logic [`ICACHE_WAYS-1:0]      hit_oh;
  way_t                         hit_way;
  way_t                         access_way;
  logic                         s1_lookup;
  logic                         s1_hit;
  logic                         s1_miss;
  logic                         stall;
  idx_t                         s1_idx;
  tag_t                         s1_tag;
  logic [`ICACHE_OFS_WIDTH-3:0] s1_word;
  plru_t                        plru_next;

  // ======================================================================
  // stage 0
  // ======================================================================
  // hold the stage-1 set on the RAMs while a miss is open
  assign stall       = s1_miss || pend_q || replay_q;
  assign req_ready_o = init_q && !stall && !flush_i;
  assign ram_raddr_o = stall ? s1_idx : req_addr_i[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];

  always_ff @(posedge clk) begin
    if (req_ready_o) begin
      s1_addr_q <= req_addr_i;
      s1_err_q  <= |req_addr_i[1:0];
    end
  end

  // ======================================================================
  // stage 1
  // ======================================================================
  assign s1_idx  = s1_addr_q[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];
  assign s1_tag  = s1_addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign s1_word = s1_addr_q[`ICACHE_OFS_WIDTH-1:2];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_oh[w] = valid_q[s1_idx][w] && (tag_rdata_i[w] == s1_tag);
      if (hit_oh[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  // no compare in the replay cycle, the RAMs are re-read then
  assign s1_lookup = s1_valid_q && !replay_q;
  assign s1_hit    = s1_lookup && !s1_err_q && (|hit_oh);
  assign s1_miss   = s1_lookup && !s1_err_q && !(|hit_oh);

  assign rsp_valid_o = s1_lookup && (s1_err_q || (|hit_oh));
  assign rsp_err_o   = s1_lookup && s1_err_q;
  assign rsp_addr_o  = s1_addr_q;
  assign rsp_instr_o = data_rdata_i[hit_way][32*s1_word +: 32];

  // one pulse per miss
  assign miss_o      = s1_miss && !pend_q;
  assign miss_addr_o = s1_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q     <= 1'b0;
      pend_q     <= 1'b0;
      replay_q   <= 1'b0;
      s1_valid_q <= 1'b0;
    end else begin
      init_q   <= 1'b1;
      replay_q <= fill_i;
      if (miss_o) begin
        pend_q <= 1'b1;
      end else if (fill_i) begin
        pend_q <= 1'b0;
      end
      if (flush_i) begin
        s1_valid_q <= 1'b0;
      end else if (req_ready_o) begin
        s1_valid_q <= req_valid_i;
      end
    end
  end

  // ======================================================================
  // RAM write control
  // ======================================================================
  // a fill touches the victim, a hit touches the hit way
  assign access_way = fill_i ? victim_o : hit_way;

  plru_tree #(
    .WAYS (`ICACHE_WAYS)
  ) u_plru_tree (
    .tree_i    (plru_rdata_i),
    .hit_way_i (access_way),
    .victim_o  (victim_o),
    .tree_o    (plru_next)
  );

  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      tag_we_o[w]  = fill_i && (victim_o == way_t'(w));
      data_we_o[w] = fill_i && (victim_o == way_t'(w));
    end
  end

  assign tag_wdata_o  = s1_tag;
  assign data_wdata_o = fill_line_i;
  assign plru_we_o    = fill_i || s1_hit;
  assign plru_wdata_o = plru_next;
  assign ram_waddr_o  = s1_idx;

  // valid bits per set and way
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill_i) begin
      valid_q[s1_idx][victim_o] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/icache_top.sv
// =========================================================================
// instruction cache top level
// lookup core, refill engine, and per-way tag and data RAMs plus one
// PLRU RAM, all indexed by set
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,
  input  logic                       req_valid_i,
  input  icache_pkg::paddr_t         req_addr_i,
  output logic                       req_ready_o,
  output logic                       rsp_valid_o,
  output icache_pkg::instr_t         rsp_instr_o,
  output icache_pkg::paddr_t         rsp_addr_o,
  output logic                       rsp_err_o,
  output logic                       ar_valid_o,
  output refill_bus_pkg::bus_addr_t  ar_addr_o,
  output refill_bus_pkg::burst_len_t ar_len_o,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  refill_bus_pkg::bus_data_t  r_data_i,
  input  logic                       r_last_i,
  output logic                       r_ready_o
);

  import icache_pkg::*;

  tag_t                    tag_rdata [`ICACHE_WAYS];
  line_t                   data_rdata [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0] tag_we;
  logic [`ICACHE_WAYS-1:0] data_we;
  tag_t                    tag_wdata;
  line_t                   data_wdata;
  logic                    plru_we;
  plru_t                   plru_wdata;
  plru_t                   plru_rdata;
  idx_t                    ram_raddr;
  idx_t                    ram_waddr;
  logic                    miss;
  paddr_t                  miss_addr;
  logic                    fill;
  line_t                   fill_line;

  icache_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_ready_o  (req_ready_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_instr_o  (rsp_instr_o),
    .rsp_addr_o   (rsp_addr_o),
    .rsp_err_o    (rsp_err_o),
    .tag_rdata_i  (tag_rdata),
    .data_rdata_i (data_rdata),
    .plru_rdata_i (plru_rdata),
    .fill_i       (fill),
    .fill_line_i  (fill_line),
    .miss_o       (miss),
    .miss_addr_o  (miss_addr),
    .victim_o     (),
    .tag_we_o     (tag_we),
    .tag_wdata_o  (tag_wdata),
    .data_we_o    (data_we),
    .data_wdata_o (data_wdata),
    .plru_we_o    (plru_we),
    .plru_wdata_o (plru_wdata),
    .ram_raddr_o  (ram_raddr),
    .ram_waddr_o  (ram_waddr)
  );

  icache_refill u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss_i      (miss),
    .miss_addr_i (miss_addr),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_last_i    (r_last_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_len_o    (ar_len_o),
    .r_ready_o   (r_ready_o),
    .fill_o      (fill),
    .fill_line_o (fill_line)
  );

  // ======================================================================
  // per-way tag and data arrays
  // ======================================================================
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    sdp_ram #(
      .payload_t (tag_t),
      .DEPTH     (`ICACHE_SETS)
    ) u_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (tag_we[w]),
      .waddr_i (ram_waddr),
      .wdata_i (tag_wdata),
      .raddr_i (ram_raddr),
      .rdata_o (tag_rdata[w])
    );

    sdp_ram #(
      .payload_t (line_t),
      .DEPTH     (`ICACHE_SETS)
    ) u_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (data_we[w]),
      .waddr_i (ram_waddr),
      .wdata_i (data_wdata),
      .raddr_i (ram_raddr),
      .rdata_o (data_rdata[w])
    );
  end

  // replacement state, one tree per set
  sdp_ram #(
    .payload_t (plru_t),
    .DEPTH     (`ICACHE_SETS)
  ) u_plru_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (plru_we),
    .waddr_i (ram_waddr),
    .wdata_i (plru_wdata),
    .raddr_i (ram_raddr),
    .rdata_o (plru_rdata)
  );

endmodule

`default_nettype wire

//--- dv/icache_mem_model.sv
// =========================================================================
// behavioral read-burst memory for the cache testbench
// the word at each address is that address inverted
// address acceptance and beat spacing stall for random cycle counts
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ar_valid_i,
  input  refill_bus_pkg::bus_addr_t  ar_addr_i,
  input  refill_bus_pkg::burst_len_t ar_len_i,
  output logic                       ar_ready_o,
  input  logic                       r_ready_i,
  output logic                       r_valid_o,
  output refill_bus_pkg::bus_data_t  r_data_o,
  output logic                       r_last_o
);

  import refill_bus_pkg::*;

  // longest random wait before ar_ready and between beats
  localparam int MAX_AR_STALL = 3;
  localparam int MAX_R_GAP    = 2;

  // outputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  initial begin : serve
    bus_addr_t  addr;
    burst_len_t len;
    logic       taken;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
      next_cycle();
      if (ar_valid_i) begin
        repeat ($urandom_range(MAX_AR_STALL)) next_cycle();
        ar_ready_o = 1'b1;
        addr       = ar_addr_i;
        len        = ar_len_i;
        next_cycle();
        ar_ready_o = 1'b0;
        for (int b = 0; b < len; b++) begin
          repeat ($urandom_range(MAX_R_GAP)) next_cycle();
          r_valid_o = 1'b1;
          r_data_o  = ~(addr + bus_addr_t'(4 * b));
          r_last_o  = (b == len - 1);
          taken     = 1'b0;
          // hold the beat until the cache takes it
          while (!taken) begin
            taken = r_ready_i;
            next_cycle();
          end
          r_valid_o = 1'b0;
          r_last_o  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/icache_properties.sv
// =========================================================================
// concurrent checks on the refill bus and the fetch response
// bound into the cache top level by the testbench
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_properties (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       ar_valid_i,
  input refill_bus_pkg::bus_addr_t  ar_addr_i,
  input refill_bus_pkg::burst_len_t ar_len_i,
  input logic                       ar_ready_i,
  input logic                       r_ready_i,
  input logic                       req_ready_i,
  input logic                       rsp_valid_i
);

  int fail_count = 0;

  // address phase holds until accepted
  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
      fail_count++;
      $error("burst request dropped or changed before ar_ready");
    end

  // full line, line aligned
  ar_shape: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i |-> (ar_len_i == `ICACHE_LINE_WORDS) &&
                   (ar_addr_i[`ICACHE_OFS_WIDTH-1:0] == '0))
    else begin
      fail_count++;
      $error("burst length or alignment is wrong");
    end

  // fetch side held off while a line is being fetched
  ready_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i || r_ready_i |-> !req_ready_i)
    else begin
      fail_count++;
      $error("fetch side ready while a refill is open");
    end

  // nothing is returned while a line streams in
  quiet_refill: assert property (@(posedge clk) disable iff (!rst_n)
    r_ready_i |-> !rsp_valid_i)
    else begin
      fail_count++;
      $error("response during refill");
    end

endmodule

`default_nettype wire

//--- dv/icache_tb.sv
// =========================================================================
// testbench of the instruction cache
// runs a table of fetches against the burst memory model, predicts
// misses with a tree PLRU model and checks every response and burst
// the tail of the table is shuffled with a seeded random order
// =========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tb;

  import icache_pkg::*;
  import refill_bus_pkg::*;

  localparam int NUM_ENTRIES  = 28;
  localparam int SHUFFLE_FROM = 21;
  // worst miss with the longest memory stalls, rounded up
  localparam int MISS_CYCLES  = 40;
  localparam int MAX_CYCLES   = NUM_ENTRIES * MISS_CYCLES + 50;

  typedef struct packed {
    paddr_t addr;
    logic   flush;
    logic   miss;
  } entry_t;

  logic       clk;
  logic       rst_n;
  logic       flush;
  logic       req_valid;
  paddr_t     req_addr;
  logic       req_ready;
  logic       rsp_valid;
  instr_t     rsp_instr;
  paddr_t     rsp_addr;
  logic       rsp_err;
  logic       ar_valid;
  bus_addr_t  ar_addr;
  burst_len_t ar_len;
  logic       ar_ready;
  logic       r_valid;
  bus_data_t  r_data;
  logic       r_last;
  logic       r_ready;

  entry_t table_q [NUM_ENTRIES];
  tag_t   model_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic   model_valid [`ICACHE_SETS][`ICACHE_WAYS];
  plru_t  model_tree [`ICACHE_SETS];
  paddr_t cur_addr;
  int     burst_count = 0;
  int     rsp_count   = 0;
  int     cycle_count = 0;

  icache_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_instr_o (rsp_instr),
    .rsp_addr_o  (rsp_addr),
    .rsp_err_o   (rsp_err),
    .ar_valid_o  (ar_valid),
    .ar_addr_o   (ar_addr),
    .ar_len_o    (ar_len),
    .ar_ready_i  (ar_ready),
    .r_valid_i   (r_valid),
    .r_data_i    (r_data),
    .r_last_i    (r_last),
    .r_ready_o   (r_ready)
  );

  icache_mem_model u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .ar_len_i   (ar_len),
    .ar_ready_o (ar_ready),
    .r_ready_i  (r_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .r_last_o   (r_last)
  );

  bind icache_top icache_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .ar_valid_i  (ar_valid_o),
    .ar_addr_i   (ar_addr_o),
    .ar_len_i    (ar_len_o),
    .ar_ready_i  (ar_ready_i),
    .r_ready_i   (r_ready_o),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // ======================================================================
  // reference model: memory rule and tree PLRU
  // ======================================================================
  function automatic instr_t expected_word(input paddr_t addr);
    return ~(addr & ~paddr_t'(3));
  endfunction

  function automatic paddr_t line_base(input paddr_t addr);
    return addr & ~(paddr_t'(`ICACHE_LINE_WORDS * 4) - 1);
  endfunction

  // root 0 picks the left pair, then the pair node picks the way
  function automatic way_t plru_victim(input plru_t t);
    if (!t[0]) begin
      return t[1] ? way_t'(1) : way_t'(0);
    end
    return t[2] ? way_t'(3) : way_t'(2);
  endfunction

  // point root and pair node away from the way just used
  function automatic plru_t plru_touch(input plru_t t, input way_t w);
    plru_t n;
    n    = t;
    n[0] = (w < 2);
    if (w < 2) begin
      n[1] = (w == 0);
    end else begin
      n[2] = (w == 2);
    end
    return n;
  endfunction

  task automatic model_access(input paddr_t addr, output logic miss);
    idx_t s;
    tag_t t;
    way_t w;
    logic hit;
    s   = addr[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH];
    t   = addr[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
    hit = 1'b0;
    w   = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (model_valid[s][i] && (model_tag[s][i] == t)) begin
        hit = 1'b1;
        w   = way_t'(i);
      end
    end
    if (!hit) begin
      w                 = plru_victim(model_tree[s]);
      model_tag[s][w]   = t;
      model_valid[s][w] = 1'b1;
    end
    model_tree[s] = plru_touch(model_tree[s], w);
    miss          = !hit;
  endtask

  // ======================================================================
  // stimulus table: address, flush, expected miss
  // ======================================================================
  task automatic load_table();
    table_q[0]  = '{32'h0000_1010, 1'b0, 1'b1};
    table_q[1]  = '{32'h0000_1014, 1'b0, 1'b0};
    table_q[2]  = '{32'h0000_1018, 1'b0, 1'b0};
    table_q[3]  = '{32'h0000_101C, 1'b0, 1'b0};
    table_q[4]  = '{32'h0000_1010, 1'b0, 1'b0};
    // misaligned, resident and cold
    table_q[5]  = '{32'h0000_1012, 1'b0, 1'b0};
    table_q[6]  = '{32'h0000_5021, 1'b0, 1'b0};
    // five lines in set 3, the fifth evicts the first
    table_q[7]  = '{32'h0000_2030, 1'b0, 1'b1};
    table_q[8]  = '{32'h0000_3034, 1'b0, 1'b1};
    table_q[9]  = '{32'h0000_4038, 1'b0, 1'b1};
    table_q[10] = '{32'h0000_503C, 1'b0, 1'b1};
    table_q[11] = '{32'h0000_6030, 1'b0, 1'b1};
    table_q[12] = '{32'h0000_3030, 1'b0, 1'b0};
    table_q[13] = '{32'h0000_4030, 1'b0, 1'b0};
    table_q[14] = '{32'h0000_5030, 1'b0, 1'b0};
    table_q[15] = '{32'h0000_6034, 1'b0, 1'b0};
    table_q[16] = '{32'h0000_2030, 1'b0, 1'b1};
    // flushed miss, then a hit on the installed line
    table_q[17] = '{32'h0000_7040, 1'b1, 1'b1};
    table_q[18] = '{32'h0000_7048, 1'b0, 1'b0};
    table_q[19] = '{32'h0000_8054, 1'b0, 1'b1};
    table_q[20] = '{32'h0000_906C, 1'b0, 1'b1};
    // hits only, order shuffled
    table_q[21] = '{32'h0000_1018, 1'b0, 1'b0};
    table_q[22] = '{32'h0000_704C, 1'b0, 1'b0};
    table_q[23] = '{32'h0000_8050, 1'b0, 1'b0};
    table_q[24] = '{32'h0000_9064, 1'b0, 1'b0};
    table_q[25] = '{32'h0000_4034, 1'b0, 1'b0};
    table_q[26] = '{32'h0000_6038, 1'b0, 1'b0};
    table_q[27] = '{32'h0000_805C, 1'b0, 1'b0};
  endtask

  task automatic shuffle_tail();
    entry_t tmp;
    int     j;
    for (int i = NUM_ENTRIES - 1; i > SHUFFLE_FROM; i--) begin
      j          = SHUFFLE_FROM + $urandom_range(i - SHUFFLE_FROM);
      tmp        = table_q[i];
      table_q[i] = table_q[j];
      table_q[j] = tmp;
    end
  endtask

  // ======================================================================
  // request driving and response collection
  // ======================================================================
  task automatic issue_request(input paddr_t addr);
    logic accepted;
    req_valid = 1'b1;
    req_addr  = addr;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = req_ready;
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  task automatic collect_response(input paddr_t addr, input logic exp_miss);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rsp_valid) begin
      waited++;
      @(negedge clk);
    end
    check(rsp_addr, addr, "response address");
    check(rsp_err, addr[1:0] != 2'b00, "response error flag");
    if (addr[1:0] == 2'b00) begin
      check(rsp_instr, expected_word(addr), "instruction word");
    end
    // hits and errors answer in the cycle after acceptance
    if (!exp_miss) begin
      check(waited, 0, "hit latency");
    end
  endtask

  task automatic flush_pending_miss();
    logic ready_seen;
    @(negedge clk);
    while (!ar_valid) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush      = 1'b0;
    ready_seen = 1'b0;
    // refill still finishes, but the request must stay silent
    while (!ready_seen) begin
      @(negedge clk);
      check(rsp_valid, 1'b0, "response of a flushed request");
      ready_seen = req_ready;
    end
  endtask

  // bus and response monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && ar_valid && ar_ready) begin
      burst_count++;
      check(ar_addr, line_base(cur_addr), "burst address");
      check(ar_len, `ICACHE_LINE_WORDS, "burst length");
    end
    if (rst_n && rsp_valid) begin
      rsp_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1, "stopped by the cycle limit");
    end
  end

  // ======================================================================
  // main sequence
  // ======================================================================
  initial begin
    entry_t e;
    logic   model_miss;
    int     bursts_before;
    int     rsps_before;
    void'($urandom(32'h2f97aee3));
    rst_n     = 1'b0;
    flush     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    cur_addr  = '0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_tree[s] = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end
    load_table();
    shuffle_tail();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      e             = table_q[n];
      cur_addr      = e.addr;
      bursts_before = burst_count;
      rsps_before   = rsp_count;
      model_miss    = 1'b0;
      if (e.addr[1:0] == 2'b00) begin
        model_access(e.addr, model_miss);
      end
      issue_request(e.addr);
      if (e.flush) begin
        flush_pending_miss();
      end else begin
        collect_response(e.addr, e.miss);
      end
      @(posedge clk);
      #1;
      check(burst_count - bursts_before, e.miss, "bursts for this fetch");
      check(model_miss, e.miss, "miss predicted by the PLRU model");
      check(rsp_count - rsps_before, !e.flush, "responses for this fetch");
      check(DUT.u_props.fail_count, 0, "bound assertion failures");
    end

    if (DUT.u_props.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache.f
+incdir+design
design/icache_pkg.sv
design/refill_bus_pkg.sv
design/sdp_ram.sv
design/plru_tree.sv
design/icache_refill.sv
design/icache_core.sv
design/icache_top.sv
dv/icache_mem_model.sv
dv/icache_properties.sv
dv/icache_tb.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - design

sources:
  - design/icache_pkg.sv
  - design/refill_bus_pkg.sv
  - design/sdp_ram.sv
  - design/plru_tree.sv
  - design/icache_refill.sv
  - design/icache_core.sv
  - design/icache_top.sv

  - target: any(simulation, test)
    files:
      - dv/icache_mem_model.sv
      - dv/icache_properties.sv
      - dv/icache_tb.sv
